// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_exec_cluster
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SRCS := $(wildcard *.sv *.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== alu_unit.sv ====
`default_nettype none

module alu_unit import tomasulo_pkg::*; (
  input  logic      clk_in,
  input  logic      rst_in,
  input  logic      disp_valid,
  input  dispatch_t disp,
  input  logic      alu_grant,
  output cdb_t      alu_result,
  output logic      alu_busy
);

  logic [4:0]  shamt;
  logic [31:0] alu_value;
  logic        load; // result register free at the next edge

  logic               res_valid;
  logic [tag_w-1:0]   res_tag;
  logic signed [31:0] res_value;

  assign shamt = disp.val2[4:0];

  always_comb begin
    case (disp.op)
      alu_add:  alu_value = disp.val1 + disp.val2;
      alu_sub:  alu_value = disp.val1 - disp.val2;
      alu_and:  alu_value = disp.val1 & disp.val2;
      alu_or:   alu_value = disp.val1 | disp.val2;
      alu_xor:  alu_value = disp.val1 ^ disp.val2;
      alu_slt:  alu_value = {31'b0, $signed(disp.val1) < $signed(disp.val2)};
      alu_sltu: alu_value = {31'b0, $unsigned(disp.val1) < $unsigned(disp.val2)};
      alu_sll:  alu_value = disp.val1 << shamt;
      alu_srl:  alu_value = $unsigned(disp.val1) >> shamt; // zero fill
      alu_sra:  alu_value = $signed(disp.val1) >>> shamt;  // sign fill
      default:  alu_value = '0;
    endcase
  end

  assign load = !res_valid || alu_grant;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      res_valid <= 1'b0;
    end else if (load) begin
      res_valid <= disp_valid; // empties on grant with nothing new behind it
    end
  end

  always_ff @(posedge clk_in) begin
    if (load && disp_valid) begin
      res_tag   <= disp.rob_tag;
      res_value <= alu_value;
    end
  end

  assign alu_result = '{valid: res_valid, tag: res_tag, value: res_value};

  // a dispatch in flight claims the result register for the next edge,
  // since the grant in that cycle is not known yet
  assign alu_busy = (res_valid && !alu_grant) || disp_valid;

  a_no_disp_while_busy: assert property (
    @(posedge clk_in) disable iff (rst_in)
    disp_valid |-> (!alu_result.valid || alu_grant)
  ) else $error("dispatch arrived while alu result was held");

endmodule

`default_nettype wire

// ==== cdb_arbiter.sv ====
`default_nettype none

module cdb_arbiter import tomasulo_pkg::*; (
  input  logic clk_in,
  input  logic rst_in,
  input  cdb_t ext_wb,
  input  cdb_t alu_result,
  output logic alu_grant,
  output cdb_t cdb
);

  logic               cdb_valid;
  logic [tag_w-1:0]   cdb_tag;
  logic signed [31:0] cdb_value;

  assign alu_grant = alu_result.valid && !ext_wb.valid; // external source first

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= ext_wb.valid || alu_result.valid;
    end
  end

  always_ff @(posedge clk_in) begin
    if (ext_wb.valid) begin
      cdb_tag   <= ext_wb.tag;
      cdb_value <= ext_wb.value;
    end else if (alu_grant) begin
      cdb_tag   <= alu_result.tag;
      cdb_value <= alu_result.value;
    end
  end

  assign cdb = '{valid: cdb_valid, tag: cdb_tag, value: cdb_value};

  // granted alu result never collides with ext_wb and lands on the bus next cycle
  a_grant_to_cdb: assert property (
    @(posedge clk_in) disable iff (rst_in)
    alu_grant |-> !ext_wb.valid ##1
      (cdb.valid && cdb.tag == $past(alu_result.tag) && cdb.value == $past(alu_result.value))
  ) else $error("granted alu result not broadcast");

  a_ext_passthrough: assert property (
    @(posedge clk_in) disable iff (rst_in)
    ext_wb.valid |=> (cdb == $past(ext_wb))
  ) else $error("external writeback altered on cdb");

endmodule

`default_nettype wire

// ==== exec_cluster.sv ====
`default_nettype none

module exec_cluster import tomasulo_pkg::*; #(
  parameter int RS_DEPTH = 4
) (
  input  logic   clk_in,
  input  logic   rst_in,
  input  logic   issue_valid,
  input  issue_t issue,
  output logic   rs_free,
  input  cdb_t   ext_wb,
  output cdb_t   cdb
);

  logic      disp_valid;
  dispatch_t disp;
  logic      alu_busy;
  cdb_t      alu_result;
  logic      alu_grant;

  reservation_station #(
    .RS_DEPTH(RS_DEPTH)
  ) u_reservation_station (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .issue_valid(issue_valid),
    .issue      (issue),
    .rs_free    (rs_free),
    .cdb        (cdb),        // snoop the broadcast
    .alu_busy   (alu_busy),
    .disp_valid (disp_valid),
    .disp       (disp)
  );

  alu_unit u_alu_unit (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .disp_valid(disp_valid),
    .disp      (disp),
    .alu_grant (alu_grant),
    .alu_result(alu_result),
    .alu_busy  (alu_busy)
  );

  cdb_arbiter u_cdb_arbiter (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .ext_wb    (ext_wb),      // e.g. a load unit
    .alu_result(alu_result),
    .alu_grant (alu_grant),
    .cdb       (cdb)
  );

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
tomasulo_pkg.sv
reservation_station.sv
alu_unit.sv
cdb_arbiter.sv
exec_cluster.sv
tb_exec_cluster.sv

// ==== reservation_station.sv ====
`default_nettype none

module reservation_station import tomasulo_pkg::*; #(
  parameter int RS_DEPTH = 4
) (
  input  logic      clk_in,
  input  logic      rst_in,
  input  logic      issue_valid,
  input  issue_t    issue,
  output logic      rs_free,
  input  cdb_t      cdb,
  input  logic      alu_busy,
  output logic      disp_valid,
  output dispatch_t disp
);

  localparam int idx_w = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

  logic [RS_DEPTH-1:0] busy; // row holds a waiting instruction
  issue_t              rows [RS_DEPTH];

  logic             free_found;
  logic [idx_w-1:0] free_idx;
  logic             ready_found;
  logic [idx_w-1:0] ready_idx;

  logic   issue_accept;
  logic   disp_fire;
  issue_t issue_snooped;

  // replace a waiting source with the broadcast value when its tag is on the bus
  function automatic operand_t snoop(operand_t src, cdb_t bus);
    operand_t res;
    res = src;
    if (!src.ready && bus.valid && (src.data.pending.tag == bus.tag)) begin
      res.ready      = 1'b1;
      res.data.value = bus.value;
    end
    return res;
  endfunction

  // lowest free row for the next issue
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin // downward so the lowest wins
      if (!busy[i]) begin
        free_found = 1'b1;
        free_idx   = idx_w'(i);
      end
    end
  end

  // lowest row with both sources resolved
  always_comb begin
    ready_found = 1'b0;
    ready_idx   = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (busy[i] && rows[i].src1.ready && rows[i].src2.ready) begin
        ready_found = 1'b1;
        ready_idx   = idx_w'(i);
      end
    end
  end

  assign rs_free      = free_found;
  assign issue_accept = issue_valid && rs_free;
  assign disp_fire    = ready_found && !alu_busy;

  // a broadcast in the issue cycle must reach the incoming entry too
  always_comb begin
    issue_snooped      = issue;
    issue_snooped.src1 = snoop(issue.src1, cdb);
    issue_snooped.src2 = snoop(issue.src2, cdb);
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy       <= '0;
      disp_valid <= 1'b0;
    end else begin
      if (issue_accept) begin
        busy[free_idx] <= 1'b1;
      end
      if (disp_fire) begin
        busy[ready_idx] <= 1'b0; // row leaves with the dispatch
      end
      disp_valid <= disp_fire; // one pulse per instruction
    end
  end

  always_ff @(posedge clk_in) begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      rows[i].src1 <= snoop(rows[i].src1, cdb); // wakeup
      rows[i].src2 <= snoop(rows[i].src2, cdb);
    end
    if (issue_accept) begin
      rows[free_idx] <= issue_snooped; // overrides the wakeup of a free row
    end
    if (disp_fire) begin
      disp.op      <= rows[ready_idx].op;
      disp.rob_tag <= rows[ready_idx].rob_tag;
      disp.val1    <= rows[ready_idx].src1.data.value;
      disp.val2    <= rows[ready_idx].src2.data.value;
    end
  end

  // issue stage has to respect rs_free
  a_no_issue_when_full: assert property (
    @(posedge clk_in) disable iff (rst_in)
    issue_valid |-> rs_free
  ) else $error("issue while reservation station is full");

endmodule

`default_nettype wire

// ==== tb_tests.svh ====
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

task automatic begin_test(input string name);
  cur_test  = name;
  test_errs = 0;
endtask

task automatic end_test();
  $display("%s finished with %0d errors", cur_test, test_errs);
endtask

task automatic step();
  @(posedge clk_in);
  #1;
endtask

task automatic expect_result(input logic [tag_w-1:0] tag, input logic [31:0] value);
  exp_pend[tag] = 1'b1;
  exp_val[tag]  = value;
endtask

task automatic drive_issue(input alu_op_e op, input logic [tag_w-1:0] tag,
                           input operand_t s1, input operand_t s2);
  issue_valid   = 1'b1;
  issue.op      = op;
  issue.rob_tag = tag;
  issue.src1    = s1;
  issue.src2    = s2;
endtask

// waits for a free row, then holds the issue for one accepting edge
task automatic send_instr(input alu_op_e op, input logic [tag_w-1:0] tag,
                          input operand_t s1, input operand_t s2);
  while (!rs_free) step();
  drive_issue(op, tag, s1, s2);
  step();
  accept_cycle = cycles;
  issue_valid  = 1'b0;
endtask

task automatic put_ext_wb(input logic [tag_w-1:0] tag, input logic [31:0] value);
  expect_result(tag, value);
  ext_wb = '{valid: 1'b1, tag: tag, value: value};
  step();
  ext_wb.valid = 1'b0;
endtask

// polled after the drive point, so the monitor has settled
task automatic wait_drain();
  while (exp_pend != '0) step();
endtask

task automatic ready_operands();
  logic [31:0]      a;
  logic [31:0]      b;
  alu_op_e          op;
  logic [tag_w-1:0] tag;
  begin_test("ready_operands");
  for (int i = 0; i < 10; i++) begin
    op  = alu_op_e'(i);
    tag = tag_w'(i);
    a   = $random(seed);
    b   = $random(seed);
    expect_result(tag, ref_alu(op, a, b));
    send_instr(op, tag, ready_src(a), ready_src(b));
    wait_drain();
    check_value("latency", 32'd3, arrive_cycle[tag] - accept_cycle);
  end
  end_test();
endtask

task automatic dependency_wakeup();
  logic [31:0] v;
  logic [31:0] b;
  begin_test("dependency_wakeup");
  v = $random(seed);
  b = $random(seed);
  expect_result(3'd1, ref_alu(alu_add, v, b));
  send_instr(alu_add, 3'd1, waiting_src(3'd5), ready_src(b));
  repeat (2) step(); // entry sits waiting
  put_ext_wb(3'd5, v);
  wait_drain();
  v = $random(seed);
  b = $random(seed);
  expect_result(3'd2, ref_alu(alu_sub, b, v));
  expect_result(3'd5, v);
  ext_wb = '{valid: 1'b1, tag: 3'd5, value: v}; // same edge as the issue
  drive_issue(alu_sub, 3'd2, ready_src(b), waiting_src(3'd5));
  step();
  issue_valid  = 1'b0;
  ext_wb.valid = 1'b0;
  wait_drain();
  v = $random(seed);
  b = $random(seed);
  expect_result(3'd3, ref_alu(alu_sll, v, b));
  put_ext_wb(3'd5, v);
  send_instr(alu_sll, 3'd3, waiting_src(3'd5), ready_src(b)); // tag 5 on the cdb right now
  wait_drain();
  end_test();
endtask

task automatic alu_chain();
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] d;
  logic [31:0] ra;
  begin_test("alu_chain");
  a  = $random(seed);
  b  = $random(seed);
  d  = $random(seed);
  ra = ref_alu(alu_add, a, b);
  expect_result(3'd0, ra);
  expect_result(3'd1, ref_alu(alu_sra, ra, d));
  send_instr(alu_add, 3'd0, ready_src(a), ready_src(b));
  send_instr(alu_sra, 3'd1, waiting_src(3'd0), ready_src(d));
  wait_drain();
  end_test();
endtask

task automatic station_capacity();
  logic [31:0] v;
  logic [31:0] b [rs_depth];
  alu_op_e     ops [rs_depth];
  begin_test("station_capacity");
  ops = '{alu_sub, alu_and, alu_sltu, alu_srl};
  v   = $random(seed);
  for (int i = 0; i < rs_depth; i++) begin
    b[i] = $random(seed);
    expect_result(tag_w'(i), ref_alu(ops[i], v, b[i]));
    send_instr(ops[i], tag_w'(i), waiting_src(3'd6), ready_src(b[i]));
  end
  check_value("rs_free when full", 32'd0, {31'b0, rs_free});
  repeat (3) step();
  put_ext_wb(3'd6, v); // releases every row at once
  wait_drain();
  end_test();
endtask

task automatic ext_backpressure();
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] v;
  alu_op_e     ops [3];
  begin_test("ext_backpressure");
  ops = '{alu_or, alu_xor, alu_slt};
  for (int k = 0; k < 5; k++) begin
    if (k < 3) begin
      a = $random(seed);
      b = $random(seed);
      expect_result(tag_w'(k), ref_alu(ops[k], a, b));
      drive_issue(ops[k], tag_w'(k), ready_src(a), ready_src(b));
    end else begin
      issue_valid = 1'b0;
    end
    v = $random(seed);
    expect_result(tag_w'(k + 3), v);
    ext_wb = '{valid: 1'b1, tag: tag_w'(k + 3), value: v}; // load unit keeps the bus
    step();
  end
  issue_valid  = 1'b0;
  ext_wb.valid = 1'b0;
  wait_drain();
  end_test();
endtask

`endif

// ==== tb_exec_cluster.sv ====
`default_nettype none

module tb_exec_cluster import tomasulo_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int rs_depth      = 4;
  localparam int n_instr       = 22; // instructions issued over all tests
  localparam int timeout_limit = n_instr * 20 + 200;

  logic   clk_in = 1'b0;
  logic   rst_in;
  logic   issue_valid;
  issue_t issue;
  logic   rs_free;
  cdb_t   ext_wb;
  cdb_t   cdb;

  integer      seed;
  int          cycles = 0;
  int          n_checks;
  int          n_fail;
  int          test_errs;
  string       cur_test;
  int          accept_cycle;
  logic [7:0]  exp_pend; // one bit per rob tag still owed on the cdb
  logic [31:0] exp_val [8];
  int          arrive_cycle [8];

  exec_cluster #(
    .RS_DEPTH(rs_depth)
  ) u_exec_cluster (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .issue_valid(issue_valid),
    .issue      (issue),
    .rs_free    (rs_free),
    .ext_wb     (ext_wb),
    .cdb        (cdb)
  );

  always #5 clk_in = ~clk_in;

  // reference for the ten integer operations
  function automatic logic [31:0] ref_alu(alu_op_e op, logic [31:0] a, logic [31:0] b);
    logic [31:0] r;
    case (op)
      alu_add:  r = a + b;
      alu_sub:  r = a + ~b + 32'd1;
      alu_and:  r = a & b;
      alu_or:   r = a | b;
      alu_xor:  r = a ^ b;
      alu_slt:  r = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0; // bias trick
      alu_sltu: r = (a < b) ? 32'd1 : 32'd0;
      alu_sll:  r = a << b[4:0];
      alu_srl:  r = a >> b[4:0];
      alu_sra:  r = (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'd0);
      default:  r = 32'd0;
    endcase
    return r;
  endfunction

  function automatic operand_t ready_src(logic [31:0] v);
    operand_t o;
    o.ready      = 1'b1;
    o.data.value = v;
    return o;
  endfunction

  function automatic operand_t waiting_src(logic [tag_w-1:0] t);
    operand_t o;
    o                  = '0;
    o.data.pending.tag = t;
    return o;
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    n_checks++;
    assert (actual === expected) else begin
      $display("Fail %s %s: expected 0x%08h, actual 0x%08h", cur_test, what, expected, actual);
      n_fail++;
      test_errs++;
    end
  endtask

  // cdb monitor, sampled away from the clock edge
  always @(negedge clk_in) begin
    if (!rst_in && cdb.valid) begin
      n_checks++;
      assert (exp_pend[cdb.tag]) else begin
        $display("%s: cdb broadcast on tag %0d that nothing was waiting for", cur_test, cdb.tag);
        n_fail++;
        test_errs++;
      end
      if (exp_pend[cdb.tag]) begin
        check_value($sformatf("tag %0d", cdb.tag), exp_val[cdb.tag], cdb.value);
        exp_pend[cdb.tag]     = 1'b0; // a second copy would show up as unexpected
        arrive_cycle[cdb.tag] = cycles;
      end
    end
  end

  always @(posedge clk_in) begin
    cycles <= cycles + 1;
    if (cycles == timeout_limit) begin
      $display("timeout after %0d cycles in %s, results never reached the cdb", cycles, cur_test);
      $display("TEST FAILED");
      $finish;
    end
  end

  `include "tb_tests.svh"

  initial begin
    seed        = 16;
    rst_in      = 1'b1;
    issue_valid = 1'b0;
    issue       = '0;
    ext_wb      = '0;
    exp_pend    = '0;
    n_checks    = 0;
    n_fail      = 0;
    cur_test    = "reset";
    repeat (8) @(posedge clk_in);
    #1;
    rst_in = 1'b0;
    check_value("rs_free", 32'd1, {31'b0, rs_free});
    check_value("cdb.valid", 32'd0, {31'b0, cdb.valid});
    ready_operands();
    dependency_wakeup();
    alu_chain();
    station_capacity();
    ext_backpressure();
    repeat (5) @(posedge clk_in); // let any stray broadcast show up
    $display("checks passed %0d, failed %0d", n_checks - n_fail, n_fail);
    if (n_fail == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tomasulo_pkg.sv ====
`default_nettype none

package tomasulo_pkg;

  localparam int tag_w = 3; // 8-entry rob

  // alu operations, encoded as in the issue stage
  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_slt  = 4'd5,
    alu_sltu = 4'd6,
    alu_sll  = 4'd7,
    alu_srl  = 4'd8,
    alu_sra  = 4'd9
  } alu_op_e;

  // one operand word, read as a value once ready, else as the producer tag
  typedef union packed {
    logic signed [31:0] value;
    struct packed {
      logic [31-tag_w:0] pad; // zero
      logic [tag_w-1:0]  tag; // rob entry that will produce the value
    } pending;
  } operand_u;

  typedef struct packed {
    logic     ready; // selects the reading of data
    operand_u data;
  } operand_t;

  typedef struct packed {
    alu_op_e          op;
    logic [tag_w-1:0] rob_tag;
    operand_t         src1;
    operand_t         src2;
  } issue_t;

  // both operands resolved
  typedef struct packed {
    alu_op_e            op;
    logic [tag_w-1:0]   rob_tag;
    logic signed [31:0] val1;
    logic signed [31:0] val2;
  } dispatch_t;

  typedef struct packed {
    logic               valid;
    logic [tag_w-1:0]   tag;
    logic signed [31:0] value;
  } cdb_t;

endpackage

`default_nettype wire
